// File: csr_map_pkg.sv
/*
 * register map of the pooling CSR block
 * offsets, version word and the per-register write strobes
 */
package csr_map_pkg;

   // --------------------
   // address space
   localparam int CSR_ADDR_W = 8;               // byte offset within the block

   typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

   localparam logic [31:0] CSR_VERSION = 32'h0002_0001;   // release word

   // --------------------
   // register offsets
   localparam csr_addr_t CSR_VERSION_A    = 8'h00;
   localparam csr_addr_t CSR_CONTROL      = 8'h10;
   localparam csr_addr_t CSR_CONFIG       = 8'h14;
   localparam csr_addr_t CSR_CONFIG_FIFO  = 8'h18;

   localparam csr_addr_t CSR_COMMAND      = 8'h20;
   localparam csr_addr_t CSR_KNL_CFG      = 8'h24;

   localparam csr_addr_t CSR_FTU_ADDR     = 8'h30;   // 0x34 left unmapped
   localparam csr_addr_t CSR_FTU_SIZE     = 8'h38;
   localparam csr_addr_t CSR_FTU_KNL      = 8'h3C;
   localparam csr_addr_t CSR_FTU_ITEMS    = 8'h40;
   localparam csr_addr_t CSR_FTU_BURST    = 8'h44;
   localparam csr_addr_t CSR_FTU_CHANNEL  = 8'h48;

   localparam csr_addr_t CSR_RST_ADDR     = 8'h50;   // 0x54 left unmapped
   localparam csr_addr_t CSR_RST_SIZE     = 8'h58;
   localparam csr_addr_t CSR_RST_ITEMS    = 8'h5C;
   localparam csr_addr_t CSR_RST_BURST    = 8'h60;

   localparam csr_addr_t CSR_PROF_CTL     = 8'h70;
   localparam csr_addr_t CSR_PROF_CYCLES  = 8'h74;
   localparam csr_addr_t CSR_PROF_CNT_RD  = 8'h78;
   localparam csr_addr_t CSR_PROF_CNT_WR  = 8'h7C;

   // --------------------
   // one strobe per writable register, at most one high per cycle
   typedef struct packed {
      logic ctl;
      logic cmd;
      logic knl;
      logic prof;
      logic ftu_addr;
      logic ftu_size;
      logic ftu_knl;
      logic ftu_items;
      logic ftu_burst;
      logic ftu_chan;
      logic rst_addr;
      logic rst_size;
      logic rst_items;
      logic rst_burst;
   } csr_wr_t;

endpackage

// File: list.f
+incdir+.
csr_map_pkg.sv
pool_cfg_pkg.sv
pool_csr_decode.sv
pool_csr_regs.sv
pool_csr_ctrl.sv
pool_csr_profile.sv
pool_csr_readmux.sv
pool_csr_top.sv
tb_pool_csr.sv

// File: pool_cfg_pkg.sv
/*
 * pooling engine configuration types
 * command codes, kernel/feature/result descriptors, profiler inputs
 */
package pool_cfg_pkg;

   // --------------------
   // command codes
   localparam logic [3:0] POOL_NOP = 4'h0;
   localparam logic [3:0] POOL_MAX = 4'h1;
   localparam logic [3:0] POOL_AVG = 4'h2;

   localparam int PROFILE_CNT_W = 32;          // engine counter width on the bus

   typedef struct packed {
      logic [3:0]  command;
      logic [3:0]  width;                       // items per kernel row
      logic [3:0]  height;
   } kernel_cfg_t;

   typedef struct packed {
      logic [31:0] address;
      logic [15:0] width;                       // items per row
      logic [15:0] height;
      logic [31:0] items;                       // width*height, set by software
      logic [3:0]  pad_pre;
      logic [3:0]  pad_post;
      logic [3:0]  stride;                      // never 0
      logic [7:0]  leng;                        // AxLEN style burst length
      logic [15:0] channel;
   } feature_cfg_t;

   typedef struct packed {
      logic [31:0] address;
      logic [15:0] width;
      logic [15:0] height;
      logic [31:0] items;
      logic [7:0]  leng;                        // AxLEN style
   } result_cfg_t;

   // --------------------
   // from the engine profiler
   typedef struct packed {
      logic                     done;           // snapshot taken
      logic [PROFILE_CNT_W-1:0] cnt_read;
      logic [PROFILE_CNT_W-1:0] cnt_write;
   } profile_in_t;

endpackage

// File: pool_csr_ctrl.sv
/*
 * control register
 * go/done handshake, engine init pulse, interrupt enable and pending
 */
`timescale 1ns/1ps

module pool_csr_ctrl (
   input  logic        CLK,
   input  logic        RESET_N,
   input  logic        wr_ctl,
   input  logic [31:0] wdata,
   input  logic        feature_done,
   input  logic        result_done,
   output logic        feature_go,
   output logic        result_go,
   output logic        pool_init,
   output logic        ie,
   output logic        ip,
   output logic        interrupt
);

   logic init_d;                          // delayed init, ends the pulse

   always_ff @(posedge CLK or negedge RESET_N) begin
      if (!RESET_N) begin
         init_d <= 1'b0;
      end else begin
         init_d <= pool_init;
      end
   end

   // --------------------
   always_ff @(posedge CLK or negedge RESET_N) begin
      if (!RESET_N) begin
         feature_go <= 1'b0;
         result_go  <= 1'b0;
         pool_init  <= 1'b0;
         ie         <= 1'b0;
         ip         <= 1'b0;
      end else if (wr_ctl) begin
         pool_init  <= wdata[31];
         ie         <= wdata[28];
         result_go  <= wdata[1];
         feature_go <= wdata[0];
         if (!wdata[29]) ip <= 1'b0;     // write 0 to clear pending
      end else begin
         if (init_d)       pool_init  <= 1'b0;
         if (feature_done) feature_go <= 1'b0;
         if (result_done)  result_go  <= 1'b0;
         if (ie && result_go && result_done) ip <= 1'b1;
      end
   end

   assign interrupt = ie & ip;

endmodule

// File: pool_csr_decode.sv
/*
 * APB address decode
 * one write strobe per register in the access phase, read enable in setup
 */
`timescale 1ns/1ps

module pool_csr_decode
   import csr_map_pkg::*;
(
   input  logic      CLK,
   input  logic      RESET_N,
   input  logic      psel,
   input  logic      penable,
   input  logic      pwrite,
   input  csr_addr_t paddr,
   output csr_wr_t   wr,
   output logic      rd_en
);

   logic wr_acc;

   assign wr_acc = psel & penable & pwrite;      // access phase only
   assign rd_en  = psel & ~penable & ~pwrite;    // setup phase only

   // --------------------
   always_comb begin
      wr = '0;
      if (wr_acc) begin
         case (paddr)
            CSR_CONTROL     : wr.ctl       = 1'b1;
            CSR_COMMAND     : wr.cmd       = 1'b1;
            CSR_KNL_CFG     : wr.knl       = 1'b1;
            CSR_PROF_CTL    : wr.prof      = 1'b1;
            CSR_FTU_ADDR    : wr.ftu_addr  = 1'b1;
            CSR_FTU_SIZE    : wr.ftu_size  = 1'b1;
            CSR_FTU_KNL     : wr.ftu_knl   = 1'b1;
            CSR_FTU_ITEMS   : wr.ftu_items = 1'b1;
            CSR_FTU_BURST   : wr.ftu_burst = 1'b1;
            CSR_FTU_CHANNEL : wr.ftu_chan  = 1'b1;
            CSR_RST_ADDR    : wr.rst_addr  = 1'b1;
            CSR_RST_SIZE    : wr.rst_size  = 1'b1;
            CSR_RST_ITEMS   : wr.rst_items = 1'b1;
            CSR_RST_BURST   : wr.rst_burst = 1'b1;
            default         : ;              // read-only or unmapped
         endcase
      end
   end

endmodule

// File: pool_csr_profile.sv
/*
 * profiler control
 * init pulse, snapshot request and the free running cycle counter
 */
`timescale 1ns/1ps

module pool_csr_profile #(
   parameter int PROFILE_CNT_WIDTH = 32
) (
   input  logic        CLK,
   input  logic        RESET_N,
   input  logic        wr_prof,
   input  logic [31:0] wdata,
   input  logic        profile_done,
   output logic        profile_init,
   output logic        profile_snapshot,
   output logic [31:0] cycles
);

   logic                         init_d;
   logic [PROFILE_CNT_WIDTH-1:0] cnt;

   // --------------------
   always_ff @(posedge CLK or negedge RESET_N) begin
      if (!RESET_N) begin
         init_d           <= 1'b0;
         profile_init     <= 1'b0;
         profile_snapshot <= 1'b0;
         cnt              <= '0;
      end else if (wr_prof) begin
         init_d           <= profile_init;
         profile_init     <= wdata[31];
         profile_snapshot <= wdata[0];
      end else begin
         init_d <= profile_init;
         if (init_d) begin                // end of init, restart counting
            profile_init     <= 1'b0;
            profile_snapshot <= 1'b0;
            cnt              <= '0;
         end else begin
            cnt <= cnt + 1'b1;
            if (profile_snapshot && profile_done) profile_snapshot <= 1'b0;
         end
      end
   end

   assign cycles = 32'(cnt);              // zero extended

endmodule

// File: pool_csr_readmux.sv
/*
 * read data multiplexer
 * builds every readback word and registers the addressed one
 */
`timescale 1ns/1ps

module pool_csr_readmux
   import csr_map_pkg::*;
   import pool_cfg_pkg::*;
#(
   parameter DATA_TYPE          = "INTEGER",
   parameter DATA_WIDTH         = 32,
   parameter FEATURE_FIFO_DEPTH = 16,
   parameter RESULT_FIFO_DEPTH  = 16
) (
   input  logic         CLK,
   input  logic         RESET_N,
   input  logic         rd_en,
   input  csr_addr_t    raddr,
   input  kernel_cfg_t  kernel,
   input  feature_cfg_t feature,
   input  result_cfg_t  result,
   input  logic         feature_go,
   input  logic         result_go,
   input  logic         feature_done,
   input  logic         result_done,
   input  logic         pool_init,
   input  logic         pool_ready,
   input  logic         ie,
   input  logic         ip,
   input  logic         profile_init,
   input  logic         profile_snapshot,
   input  logic [31:0]  cycles,
   input  profile_in_t  prof,
   output logic [31:0]  rdata
);

   logic [15:0] type_word;                // two letters, low byte first
   logic [31:0] ctl_word;
   logic [31:0] rd_word;

   assign type_word = (DATA_TYPE == "FLOATING_POINT") ? {"P", "F"} : {"T", "I"};

   assign ctl_word = {pool_init, pool_ready, ip, ie,
                      18'h0,
                      result_done, feature_done,
                      6'h0,
                      result_go, feature_go};

   // --------------------
   // word select
   always_comb begin
      case (raddr)
         CSR_VERSION_A   : rd_word = CSR_VERSION;
         CSR_CONTROL     : rd_word = ctl_word;
         CSR_CONFIG      : rd_word = {type_word, 8'h0, 8'(DATA_WIDTH)};  // no fraction
         CSR_CONFIG_FIFO : rd_word = {16'h0, 8'(RESULT_FIFO_DEPTH), 8'(FEATURE_FIFO_DEPTH)};
         CSR_COMMAND     : rd_word = {28'h0, kernel.command};
         CSR_KNL_CFG     : rd_word = {24'h0, kernel.height, kernel.width};
         CSR_FTU_ADDR    : rd_word = feature.address;
         CSR_FTU_SIZE    : rd_word = {feature.height, feature.width};
         CSR_FTU_KNL     : rd_word = {16'h0, feature.pad_post, feature.pad_pre,
                                      4'h0, feature.stride};
         CSR_FTU_ITEMS   : rd_word = feature.items;
         CSR_FTU_BURST   : rd_word = {24'h0, feature.leng};
         CSR_FTU_CHANNEL : rd_word = {16'h0, feature.channel};
         CSR_RST_ADDR    : rd_word = result.address;
         CSR_RST_SIZE    : rd_word = {result.height, result.width};
         CSR_RST_ITEMS   : rd_word = result.items;
         CSR_RST_BURST   : rd_word = {24'h0, result.leng};
         CSR_PROF_CTL    : rd_word = {profile_init, 29'h0, prof.done, profile_snapshot};
         CSR_PROF_CYCLES : rd_word = cycles;
         CSR_PROF_CNT_RD : rd_word = prof.cnt_read;
         CSR_PROF_CNT_WR : rd_word = prof.cnt_write;
         default         : rd_word = 32'h0;   // unmapped
      endcase
   end

   // --------------------
   // registered in setup phase, zero otherwise
   always_ff @(posedge CLK or negedge RESET_N) begin
      if (!RESET_N) begin
         rdata <= 32'h0;
      end else begin
         rdata <= rd_en ? rd_word : 32'h0;
      end
   end

endmodule

// File: pool_csr_regs.sv
/*
 * pooling descriptor registers
 * kernel, feature-map and result-map fields with their reset values
 */
`timescale 1ns/1ps

module pool_csr_regs
   import csr_map_pkg::*;
   import pool_cfg_pkg::*;
(
   input  logic         CLK,
   input  logic         RESET_N,
   input  csr_wr_t      wr,
   input  logic [31:0]  wdata,
   output kernel_cfg_t  kernel,
   output feature_cfg_t feature,
   output result_cfg_t  result
);

   // --------------------
   // kernel
   always_ff @(posedge CLK or negedge RESET_N) begin
      if (!RESET_N) begin
         kernel.command <= POOL_NOP;
         kernel.width   <= 4'h0;
         kernel.height  <= 4'h0;
      end else begin
         if (wr.cmd) kernel.command <= wdata[3:0];
         if (wr.knl) begin
            kernel.height <= wdata[7:4];
            kernel.width  <= wdata[3:0];
         end
      end
   end

   // --------------------
   // feature map
   always_ff @(posedge CLK or negedge RESET_N) begin
      if (!RESET_N) begin
         feature          <= '0;
         feature.stride   <= 4'h1;         // unit stride
      end else begin
         if (wr.ftu_addr) feature.address <= wdata;
         if (wr.ftu_size) begin
            feature.height <= wdata[31:16];
            feature.width  <= wdata[15:0];
         end
         if (wr.ftu_knl) begin
            feature.pad_post <= wdata[15:12];
            feature.pad_pre  <= wdata[11:8];
            // stride 0 has no meaning, taken as 1
            feature.stride   <= (wdata[3:0] == 4'h0) ? 4'h1 : wdata[3:0];
         end
         if (wr.ftu_items) feature.items   <= wdata;
         if (wr.ftu_burst) feature.leng    <= wdata[7:0];
         if (wr.ftu_chan)  feature.channel <= wdata[15:0];
      end
   end

   // --------------------
   // result map
   always_ff @(posedge CLK or negedge RESET_N) begin
      if (!RESET_N) begin
         result <= '0;
      end else begin
         if (wr.rst_addr) result.address <= wdata;
         if (wr.rst_size) begin
            result.height <= wdata[31:16];
            result.width  <= wdata[15:0];
         end
         if (wr.rst_items) result.items <= wdata;
         if (wr.rst_burst) result.leng  <= wdata[7:0];
      end
   end

endmodule

// File: pool_csr_top.sv
/*
 * pooling CSR block top level
 * APB slave port, engine configuration outputs and status inputs
 */
`timescale 1ns/1ps

module pool_csr_top
   import csr_map_pkg::*;
   import pool_cfg_pkg::*;
#(
   parameter DATA_TYPE          = "INTEGER",
   parameter DATA_WIDTH         = 32,
   parameter FEATURE_FIFO_DEPTH = 16,
   parameter RESULT_FIFO_DEPTH  = 16,
   parameter PROFILE_CNT_WIDTH  = 32
) (
   input  logic         CLK,
   input  logic         RESET_N,
   // --------------------
   // APB
   input  logic         PSEL,
   input  logic         PENABLE,
   input  csr_addr_t    PADDR,
   input  logic         PWRITE,
   input  logic [31:0]  PWDATA,
   output logic [31:0]  PRDATA,
   // --------------------
   // engine
   output kernel_cfg_t  kernel,
   output feature_cfg_t feature,
   output result_cfg_t  result,
   output logic         feature_go,
   input  logic         feature_done,
   output logic         result_go,
   input  logic         result_done,
   output logic         pool_init,
   input  logic         pool_ready,
   output logic         profile_init,
   output logic         profile_snapshot,
   input  profile_in_t  prof,
   output logic         interrupt
);

   csr_wr_t     wr;
   logic        rd_en;
   logic        ie;
   logic        ip;
   logic [31:0] cycles;

   pool_csr_decode u_decode (
      .CLK     (CLK),
      .RESET_N (RESET_N),
      .psel    (PSEL),
      .penable (PENABLE),
      .pwrite  (PWRITE),
      .paddr   (PADDR),
      .wr      (wr),
      .rd_en   (rd_en)
   );

   pool_csr_regs u_regs (
      .CLK     (CLK),
      .RESET_N (RESET_N),
      .wr      (wr),
      .wdata   (PWDATA),
      .kernel  (kernel),
      .feature (feature),
      .result  (result)
   );

   pool_csr_ctrl u_ctrl (
      .CLK          (CLK),
      .RESET_N      (RESET_N),
      .wr_ctl       (wr.ctl),
      .wdata        (PWDATA),
      .feature_done (feature_done),
      .result_done  (result_done),
      .feature_go   (feature_go),
      .result_go    (result_go),
      .pool_init    (pool_init),
      .ie           (ie),
      .ip           (ip),
      .interrupt    (interrupt)
   );

   pool_csr_profile #(
      .PROFILE_CNT_WIDTH (PROFILE_CNT_WIDTH)
   ) u_profile (
      .CLK              (CLK),
      .RESET_N          (RESET_N),
      .wr_prof          (wr.prof),
      .wdata            (PWDATA),
      .profile_done     (prof.done),
      .profile_init     (profile_init),
      .profile_snapshot (profile_snapshot),
      .cycles           (cycles)
   );

   pool_csr_readmux #(
      .DATA_TYPE          (DATA_TYPE),
      .DATA_WIDTH         (DATA_WIDTH),
      .FEATURE_FIFO_DEPTH (FEATURE_FIFO_DEPTH),
      .RESULT_FIFO_DEPTH  (RESULT_FIFO_DEPTH)
   ) u_readmux (
      .CLK              (CLK),
      .RESET_N          (RESET_N),
      .rd_en            (rd_en),
      .raddr            (PADDR),
      .kernel           (kernel),
      .feature          (feature),
      .result           (result),
      .feature_go       (feature_go),
      .result_go        (result_go),
      .feature_done     (feature_done),
      .result_done      (result_done),
      .pool_init        (pool_init),
      .pool_ready       (pool_ready),
      .ie               (ie),
      .ip               (ip),
      .profile_init     (profile_init),
      .profile_snapshot (profile_snapshot),
      .cycles           (cycles),
      .prof             (prof),
      .rdata            (PRDATA)
   );

endmodule

// File: tb_pool_csr_tasks.svh
/*
 * testbench helpers
 * APB write and read, value check, LFSR source, engine done model
 */

// --------------------
// APB master, inputs change 2 ns after the edge
task automatic apb_write(input csr_addr_t addr, input logic [31:0] data);
   @(posedge CLK);
   #2;
   psel    = 1'b1;
   penable = 1'b0;
   pwrite  = 1'b1;
   paddr   = addr;
   pwdata  = data;
   @(posedge CLK);
   #2;
   penable = 1'b1;                      // access phase
   @(posedge CLK);
   #2;
   psel    = 1'b0;
   penable = 1'b0;
   pwrite  = 1'b0;
endtask

task automatic apb_read(input csr_addr_t addr, output logic [31:0] data);
   @(posedge CLK);
   #2;
   psel    = 1'b1;
   penable = 1'b0;
   pwrite  = 1'b0;
   paddr   = addr;
   @(posedge CLK);
   #2;
   penable = 1'b1;
   data    = prdata;                    // registered at end of setup
   @(posedge CLK);
   #2;
   psel    = 1'b0;
   penable = 1'b0;
endtask

task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
   checks++;
   if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %08h actual %08h", name, exp, act);
   end
endtask

// --------------------
// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
   return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

task automatic random_bits(input int nbits, output logic [31:0] w);
   w = '0;
   for (int i = 0; i < nbits; i++) begin
      lfsr = lfsr_step(lfsr);
      w    = {w[30:0], lfsr[0]};           // one step per bit
   end
endtask

// --------------------
// engine model, done a few cycles after go
task automatic respond_done(input int delay);
   int n;
   n = 0;
   while (!(feature_go | result_go) && n < TIMEOUT) begin
      @(posedge CLK);
      #2;
      n++;
   end
   if (n >= TIMEOUT) begin
      timeouts++;
      $display("timeout: no go bit rose for the engine model");
   end
   repeat (delay) @(posedge CLK);
   #2;
   feature_done = 1'b1;
   result_done  = 1'b1;
   n = 0;
   while ((feature_go | result_go) && n < TIMEOUT) begin
      @(posedge CLK);
      #2;
      n++;
   end
   if (n >= TIMEOUT) begin
      timeouts++;
      $display("timeout: go bits stayed high after done");
   end
endtask

task automatic release_done();
   @(posedge CLK);
   #2;
   feature_done = 1'b0;
   result_done  = 1'b0;
endtask

// File: tb_pool_csr.sv
/*
 * testbench for the pooling CSR block
 * clock, reset, DUT, register table and the engine scenarios
 */
`timescale 1ns/1ps

module tb_pool_csr
   import csr_map_pkg::*;
   import pool_cfg_pkg::*;
();

   localparam int TIMEOUT = 200;                  // cycles per wait
   localparam int DATA_W  = 32;
   localparam int FEAT_D  = 16;
   localparam int RES_D   = 16;
   localparam logic [31:0] EXP_CONFIG = {"TI", 8'h00, 8'(DATA_W)};
   localparam logic [31:0] EXP_FIFO   = {16'h0, 8'(RES_D), 8'(FEAT_D)};

   // one table entry per register step
   typedef struct packed {
      csr_addr_t   off;
      logic        port;                          // has an output field
      logic [31:0] wdata;
      logic [31:0] exp_rd;
      logic [31:0] exp_port;
   } step_t;

   logic         CLK;
   logic         RESET_N;
   logic         psel, penable, pwrite;
   csr_addr_t    paddr;
   logic [31:0]  pwdata, prdata;
   kernel_cfg_t  kernel;
   feature_cfg_t feature;
   result_cfg_t  result;
   logic         feature_go, feature_done, result_go, result_done;
   logic         pool_init, pool_ready, profile_init, profile_snapshot;
   logic         interrupt;
   profile_in_t  prof;

   int           checks, errors, timeouts;
   logic [31:0]  lfsr;
   step_t        steps [0:31];
   int           nstep;

   `include "tb_pool_csr_tasks.svh"

   pool_csr_top #(
      .DATA_TYPE          ("INTEGER"),
      .DATA_WIDTH         (DATA_W),
      .FEATURE_FIFO_DEPTH (FEAT_D),
      .RESULT_FIFO_DEPTH  (RES_D),
      .PROFILE_CNT_WIDTH  (32)
   ) dut0 (
      .CLK (CLK), .RESET_N (RESET_N),
      .PSEL (psel), .PENABLE (penable), .PADDR (paddr), .PWRITE (pwrite),
      .PWDATA (pwdata), .PRDATA (prdata),
      .kernel (kernel), .feature (feature), .result (result),
      .feature_go (feature_go), .feature_done (feature_done),
      .result_go (result_go), .result_done (result_done),
      .pool_init (pool_init), .pool_ready (pool_ready),
      .profile_init (profile_init), .profile_snapshot (profile_snapshot),
      .prof (prof), .interrupt (interrupt)
   );

   always #10 CLK = ~CLK;                         // 20 ns period

   // --------------------
   // register table
   task automatic add_step(input csr_addr_t off, input logic [31:0] mask, input logic port,
                           input logic stride0);
      step_t       s;
      logic [31:0] w;
      random_bits(32, w);
      if (stride0) w[3:0] = 4'h0;
      s.off    = off;
      s.port   = port;
      s.wdata  = w;
      s.exp_rd = w & mask;
      if (off == CSR_FTU_KNL && s.exp_rd[3:0] == 4'h0) s.exp_rd[3:0] = 4'h1;   // stride 0 -> 1
      s.exp_port   = port ? s.exp_rd : 32'h0;
      steps[nstep] = s;
      nstep++;
   endtask

   // output fields packed in readback layout
   function automatic logic [31:0] port_word(input csr_addr_t off);
      case (off)
         CSR_COMMAND     : port_word = {28'h0, kernel.command};
         CSR_KNL_CFG     : port_word = {24'h0, kernel.height, kernel.width};
         CSR_FTU_ADDR    : port_word = feature.address;
         CSR_FTU_SIZE    : port_word = {feature.height, feature.width};
         CSR_FTU_KNL     : port_word = {16'h0, feature.pad_post, feature.pad_pre, 4'h0,
                                        feature.stride};
         CSR_FTU_ITEMS   : port_word = feature.items;
         CSR_FTU_BURST   : port_word = {24'h0, feature.leng};
         CSR_FTU_CHANNEL : port_word = {16'h0, feature.channel};
         CSR_RST_ADDR    : port_word = result.address;
         CSR_RST_SIZE    : port_word = {result.height, result.width};
         CSR_RST_ITEMS   : port_word = result.items;
         CSR_RST_BURST   : port_word = {24'h0, result.leng};
         default         : port_word = 32'h0;
      endcase
   endfunction

   task automatic pulse_width(input logic prof_sel, output int width);
      width = 0;
      while ((prof_sel ? profile_init : pool_init) && width < TIMEOUT) begin
         width++;
         @(posedge CLK);
         #2;
      end
      if (width >= TIMEOUT) begin
         timeouts++;
         $display("timeout: init pulse did not end");
      end
   endtask

   // --------------------
   initial begin
      logic [31:0] rd, c0, c1, cnt_rd, cnt_wr;
      int          width;
      int          n;
      CLK = 1'b0;   RESET_N = 1'b0;
      psel = 1'b0;  penable = 1'b0;  pwrite = 1'b0;  paddr = '0;  pwdata = '0;
      feature_done = 1'b0;  result_done = 1'b0;  pool_ready = 1'b0;  prof = '0;
      checks = 0;  errors = 0;  timeouts = 0;  nstep = 0;
      lfsr = 32'h40ca3e2d;
      add_step(CSR_COMMAND,     32'h0000_000F, 1'b1, 1'b0);
      add_step(CSR_KNL_CFG,     32'h0000_00FF, 1'b1, 1'b0);
      add_step(CSR_FTU_ADDR,    32'hFFFF_FFFF, 1'b1, 1'b0);
      add_step(CSR_FTU_SIZE,    32'hFFFF_FFFF, 1'b1, 1'b0);
      add_step(CSR_FTU_KNL,     32'h0000_FF0F, 1'b1, 1'b0);
      add_step(CSR_FTU_ITEMS,   32'hFFFF_FFFF, 1'b1, 1'b0);
      add_step(CSR_FTU_BURST,   32'h0000_00FF, 1'b1, 1'b0);
      add_step(CSR_FTU_CHANNEL, 32'h0000_FFFF, 1'b1, 1'b0);
      add_step(CSR_RST_ADDR,    32'hFFFF_FFFF, 1'b1, 1'b0);
      add_step(CSR_RST_SIZE,    32'hFFFF_FFFF, 1'b1, 1'b0);
      add_step(CSR_RST_ITEMS,   32'hFFFF_FFFF, 1'b1, 1'b0);
      add_step(CSR_RST_BURST,   32'h0000_00FF, 1'b1, 1'b0);
      add_step(CSR_FTU_KNL,     32'h0000_FF0F, 1'b1, 1'b1);   // stride written as 0
      add_step(8'h34,           32'h0000_0000, 1'b0, 1'b0);   // former upper address words
      add_step(8'h54,           32'h0000_0000, 1'b0, 1'b0);
      add_step(8'h28,           32'h0000_0000, 1'b0, 1'b0);   // unmapped
      add_step(8'hFC,           32'h0000_0000, 1'b0, 1'b0);
      repeat (16) @(posedge CLK);
      #2;
      RESET_N = 1'b1;

      // after reset
      check("reset outputs", 32'h0, {26'h0, feature_go, result_go, pool_init, interrupt,
                                     profile_init, profile_snapshot});
      apb_read(CSR_VERSION_A, rd);    check("version", CSR_VERSION, rd);
      apb_read(CSR_CONFIG, rd);       check("config", EXP_CONFIG, rd);
      apb_read(CSR_CONFIG_FIFO, rd);  check("fifo config", EXP_FIFO, rd);
      apb_read(CSR_CONTROL, rd);      check("reset control", 32'h0, rd);
      apb_read(CSR_PROF_CTL, rd);     check("reset profile control", 32'h0, rd);
      apb_read(CSR_PROF_CNT_RD, rd);  check("reset read count", 32'h0, rd);
      apb_read(CSR_PROF_CNT_WR, rd);  check("reset write count", 32'h0, rd);
      for (int i = 0; i < nstep; i++) begin
         apb_read(steps[i].off, rd);
         check($sformatf("reset 0x%02h", steps[i].off),
               (steps[i].off == CSR_FTU_KNL) ? 32'h1 : 32'h0, rd);
      end

      // configuration table
      for (int i = 0; i < nstep; i++) begin
         apb_write(steps[i].off, steps[i].wdata);
         if (steps[i].port)
            check($sformatf("port 0x%02h", steps[i].off), steps[i].exp_port,
                  port_word(steps[i].off));
         apb_read(steps[i].off, rd);
         check($sformatf("read 0x%02h", steps[i].off), steps[i].exp_rd, rd);
      end

      // go bits and done
      pool_ready = 1'b1;
      apb_write(CSR_CONTROL, 32'h0000_0003);
      check("go raised", 32'h3, {30'h0, feature_go, result_go});
      respond_done(3);
      apb_read(CSR_CONTROL, rd);      check("control after done", 32'h4000_0300, rd);
      release_done();
      pool_ready = 1'b0;

      // interrupt, enabled then masked
      apb_write(CSR_CONTROL, 32'h1000_0003);
      respond_done(2);
      check("interrupt raised", 32'h1, {31'h0, interrupt});
      apb_read(CSR_CONTROL, rd);      check("control pending", 32'h3000_0300, rd);
      release_done();
      apb_write(CSR_CONTROL, 32'h3000_0000);                   // bit 29 set keeps ip
      check("interrupt kept", 32'h1, {31'h0, interrupt});
      apb_write(CSR_CONTROL, 32'h1000_0000);
      check("interrupt cleared", 32'h0, {31'h0, interrupt});
      apb_read(CSR_CONTROL, rd);      check("control cleared", 32'h1000_0000, rd);
      apb_write(CSR_CONTROL, 32'h0000_0003);
      respond_done(2);
      check("interrupt masked", 32'h0, {31'h0, interrupt});
      apb_read(CSR_CONTROL, rd);      check("control masked", 32'h0000_0300, rd);
      release_done();

      // init pulses and cycle counter
      apb_write(CSR_CONTROL, 32'h8000_0000);
      pulse_width(1'b0, width);       check("pool_init width", 32'd2, 32'(width));
      apb_write(CSR_PROF_CTL, 32'h8000_0000);
      pulse_width(1'b1, width);       check("profile_init width", 32'd2, 32'(width));
      apb_read(CSR_PROF_CYCLES, c0);  check("cycles small", 32'h1, {31'h0, c0 < 32'd16});
      apb_read(CSR_PROF_CYCLES, c1);  check("cycles grow", 32'h1, {31'h0, c1 > c0});

      // snapshot request
      apb_write(CSR_PROF_CTL, 32'h0000_0001);
      check("snapshot raised", 32'h1, {31'h0, profile_snapshot});
      repeat (3) @(posedge CLK);
      #2;
      check("snapshot held", 32'h1, {31'h0, profile_snapshot});
      random_bits(32, cnt_rd);
      random_bits(32, cnt_wr);
      prof.cnt_read  = cnt_rd;
      prof.cnt_write = cnt_wr;
      prof.done      = 1'b1;
      n = 0;
      while (profile_snapshot && n < TIMEOUT) begin
         @(posedge CLK);
         #2;
         n++;
      end
      if (n >= TIMEOUT) begin
         timeouts++;
         $display("timeout: snapshot request never cleared");
      end
      apb_read(CSR_PROF_CTL, rd);     check("profile control", 32'h0000_0002, rd);
      apb_read(CSR_PROF_CNT_RD, rd);  check("read count", cnt_rd, rd);
      apb_read(CSR_PROF_CNT_WR, rd);  check("write count", cnt_wr, rd);
      prof.done = 1'b0;

      $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule
